// File: verilog/calc_pkg.sv
`default_nettype none

package calc_pkg;

    // keypad position, row * 4 + column
    typedef logic [3:0] key_code_t;

    // decimal digit, NO_DIGIT when the key is not a digit
    typedef logic [3:0] digit_t;

    typedef logic [2:0] op_code_t;           // operator code from the keypad

    typedef logic signed [15:0] value_t;     // accumulator and typed number

    typedef logic [15:0] bcd_t;              // four bcd digits, msd first

    localparam digit_t NO_DIGIT = 4'd15;     // key is not a digit

    // operator codes
    localparam op_code_t OP_NONE = 3'd0;
    localparam op_code_t OP_NEG  = 3'd1;     // sign flip, applied at once
    localparam op_code_t OP_ADD  = 3'd2;
    localparam op_code_t OP_SUB  = 3'd3;
    localparam op_code_t OP_MUL  = 3'd4;

    // stable cycles before a key counts as pressed
    localparam int DEBOUNCE_CYCLES = 10;
    localparam int DEBOUNCE_W      = $clog2(DEBOUNCE_CYCLES + 1);

    localparam int MAX_DIGITS  = 4;          // extra digits dropped
    localparam int DIGIT_CNT_W = $clog2(MAX_DIGITS + 1);

    localparam int DISPLAY_LIMIT = 9999;     // largest magnitude shown
    localparam int DISPLAY_BITS  = $clog2(DISPLAY_LIMIT + 1);

endpackage

`default_nettype wire

// File: verilog/input_control.sv
`timescale 1ns/100ps
`default_nettype none

module input_control import calc_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] row_in,          // active low, pulled up
    input  logic       key_rd,          // consume pulse from the core
    output logic [3:0] col_out,         // one-cold column drive
    output logic       key_rdy,         // key confirmed, held until release
    output digit_t     keypad_input,    // 0..9 or NO_DIGIT
    output op_code_t   operator_input,
    output logic       equal_input      // * key
);

    typedef enum logic [2:0] {
        IDLE,
        SCAN_COL,
        WAIT_STABLE,
        CONFIRM,
        WAIT_RELEASE
    } state_t;

    state_t                state, next_state;
    logic [1:0]            col_index;       // column being driven low
    logic [DEBOUNCE_W-1:0] debounce_cnt;
    key_code_t             key_code;        // captured once per press
    logic                  key_valid;       // some row pulled low
    logic                  stable_done;
    logic                  capture;

    assign key_valid   = ~&row_in;
    assign stable_done = key_valid && (debounce_cnt == DEBOUNCE_W'(DEBOUNCE_CYCLES - 1));
    assign capture     = (state == CONFIRM) && !key_rdy && key_valid;

    // lowest pulled row wins
    function automatic key_code_t encode_key(input logic [3:0] row, input logic [1:0] col);
        key_code_t code;
        code = '0;
        for (int r = 3; r >= 0; r--) begin
            if (!row[r])
                code = {2'(r), col};
        end
        return code;
    endfunction

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state        <= IDLE;
            col_index    <= '0;
            debounce_cnt <= '0;
            key_rdy      <= 1'b0;
        end else begin
            state <= next_state;
            if (state == SCAN_COL && !key_valid)
                col_index <= col_index + 2'd1;      // move on, wraps at 3
            if (state == WAIT_STABLE && key_valid)
                debounce_cnt <= debounce_cnt + 1'b1;
            else
                debounce_cnt <= '0;                 // bounce restarts count
            if (capture)
                key_rdy <= 1'b1;
            if (state == WAIT_RELEASE && !key_valid)
                key_rdy <= 1'b0;                    // all rows back high
        end
    end

    always_ff @(posedge clk) begin
        if (capture)
            key_code <= encode_key(row_in, col_index);
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:        next_state = SCAN_COL;
            SCAN_COL:    next_state = key_valid ? WAIT_STABLE : SCAN_COL;
            WAIT_STABLE: begin
                if (!key_valid)
                    next_state = SCAN_COL;          // lost the row, rescan
                else if (stable_done)
                    next_state = CONFIRM;
            end
            CONFIRM: begin
                if (key_rdy)
                    next_state = key_rd ? WAIT_RELEASE : CONFIRM;   // hold until read
                else if (!key_valid)
                    next_state = SCAN_COL;
            end
            WAIT_RELEASE: next_state = key_valid ? WAIT_RELEASE : IDLE;
            default:      next_state = IDLE;
        endcase
    end

    always_comb begin
        col_out            = 4'b1111;
        col_out[col_index] = 1'b0;
    end

    // keypad legend 1 2 3 A / 4 5 6 B / 7 8 9 C / * 0 # D
    always_comb begin
        keypad_input   = NO_DIGIT;
        operator_input = OP_NONE;
        equal_input    = 1'b0;
        case (key_code)
            4'h0: keypad_input   = 4'd1;
            4'h1: keypad_input   = 4'd2;
            4'h2: keypad_input   = 4'd3;
            4'h3: operator_input = OP_ADD;          // A
            4'h4: keypad_input   = 4'd4;
            4'h5: keypad_input   = 4'd5;
            4'h6: keypad_input   = 4'd6;
            4'h7: operator_input = OP_SUB;          // B
            4'h8: keypad_input   = 4'd7;
            4'h9: keypad_input   = 4'd8;
            4'hA: keypad_input   = 4'd9;
            4'hB: operator_input = OP_MUL;          // C
            4'hC: equal_input    = 1'b1;            // *
            4'hD: keypad_input   = 4'd0;
            4'hF: operator_input = OP_NEG;          // D
            default: ;                              // # does nothing
        endcase
    end

    a_rdy_from_confirm: assert property (@(posedge clk) disable iff (!nRST)
        $rose(key_rdy) |-> $past(state) == CONFIRM);

    a_key_held: assert property (@(posedge clk) disable iff (!nRST)
        key_rdy && $past(key_rdy) |-> $stable({keypad_input, operator_input, equal_input}));

endmodule

`default_nettype wire

// File: verilog/calc_core.sv
`timescale 1ns/100ps
`default_nettype none

module calc_core import calc_pkg::*; (
    input  logic     clk,
    input  logic     nRST,
    input  logic     key_rdy,
    input  digit_t   keypad_input,
    input  op_code_t operator_input,
    input  logic     equal_input,
    output logic     key_rd,            // one pulse per key
    output value_t   show_value         // entry while typing, else acc
);

    logic                   key_rdy_q;
    logic                   take_key;   // first cycle of key_rdy
    value_t                 acc, acc_n;
    value_t                 entry, entry_n;
    logic [DIGIT_CNT_W-1:0] digit_cnt, digit_cnt_n;
    op_code_t               pend_op, pend_op_n;
    logic                   entering, entering_n;

    // 16 bit wrapping arithmetic
    function automatic value_t apply_op(input op_code_t op, input value_t a, input value_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_MUL:  return a * b;
            default: return a;
        endcase
    endfunction

    assign take_key = key_rdy && !key_rdy_q;

    always_comb begin
        acc_n       = acc;
        entry_n     = entry;
        digit_cnt_n = digit_cnt;
        pend_op_n   = pend_op;
        entering_n  = entering;
        if (take_key) begin
            if (keypad_input != NO_DIGIT) begin
                if (!entering) begin                        // first digit
                    entry_n     = value_t'(keypad_input);
                    digit_cnt_n = DIGIT_CNT_W'(1);
                    entering_n  = 1'b1;
                end else if (digit_cnt < MAX_DIGITS) begin
                    entry_n     = entry * value_t'(10) + value_t'(keypad_input);
                    digit_cnt_n = digit_cnt + 1'b1;
                end
            end else if (operator_input == OP_NEG) begin
                if (entering)
                    entry_n = -entry;
                else
                    acc_n = -acc;
            end else if (operator_input inside {OP_ADD, OP_SUB, OP_MUL}) begin
                if (entering && pend_op != OP_NONE)
                    acc_n = apply_op(pend_op, acc, entry);  // chain left to right
                else if (entering)
                    acc_n = entry;
                pend_op_n  = operator_input;
                entering_n = 1'b0;
            end else if (equal_input) begin
                if (entering && pend_op != OP_NONE) begin
                    acc_n     = apply_op(pend_op, acc, entry);
                    pend_op_n = OP_NONE;
                end else if (entering) begin
                    acc_n = entry;
                end
                entering_n = 1'b0;
            end
            // anything else is just acknowledged
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            key_rdy_q  <= 1'b0;
            key_rd     <= 1'b0;
            acc        <= '0;
            pend_op    <= OP_NONE;
            entering   <= 1'b0;
            show_value <= '0;
        end else begin
            key_rdy_q  <= key_rdy;
            key_rd     <= take_key;
            acc        <= acc_n;
            pend_op    <= pend_op_n;
            entering   <= entering_n;
            show_value <= entering_n ? entry_n : acc_n;
        end
    end

    always_ff @(posedge clk) begin
        entry     <= entry_n;       // only read while entering
        digit_cnt <= digit_cnt_n;
    end

    a_rd_single: assert property (@(posedge clk) disable iff (!nRST)
        key_rd |=> !key_rd);

endmodule

`default_nettype wire

// File: verilog/display_format.sv
`timescale 1ns/100ps
`default_nettype none

module display_format import calc_pkg::*; (
    input  logic   clk,
    input  logic   nRST,
    input  value_t show_value,
    output logic   disp_neg,        // minus sign
    output bcd_t   disp_bcd,        // zero on error
    output logic   disp_err         // magnitude too large
);

    logic [$bits(value_t)-1:0] magnitude;   // -32768 maps to 32768
    logic                      over_limit;

    // shift and add 3, one input bit per step
    function automatic bcd_t bin_to_bcd(input logic [DISPLAY_BITS-1:0] bin);
        bcd_t bcd;
        bcd = '0;
        for (int i = DISPLAY_BITS - 1; i >= 0; i--) begin
            for (int d = 0; d < 4; d++) begin
                if (bcd[d*4 +: 4] > 4'd4)
                    bcd[d*4 +: 4] = bcd[d*4 +: 4] + 4'd3;
            end
            bcd = {bcd[14:0], bin[i]};
        end
        return bcd;
    endfunction

    assign magnitude  = show_value[15] ? -show_value : show_value;
    assign over_limit = magnitude > DISPLAY_LIMIT;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            disp_neg <= 1'b0;
            disp_bcd <= '0;
            disp_err <= 1'b0;
        end else begin
            disp_neg <= show_value[15];
            disp_err <= over_limit;
            if (over_limit)
                disp_bcd <= '0;
            else
                disp_bcd <= bin_to_bcd(magnitude[DISPLAY_BITS-1:0]);   // fits below 10000
        end
    end

    a_bcd_digits: assert property (@(posedge clk) disable iff (!nRST)
        (disp_bcd[15:12] <= 4'd9) && (disp_bcd[11:8] <= 4'd9) &&
        (disp_bcd[7:4] <= 4'd9) && (disp_bcd[3:0] <= 4'd9));

endmodule

`default_nettype wire

// File: verilog/calculator_top.sv
`timescale 1ns/100ps
`default_nettype none

module calculator_top import calc_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] row_in,      // keypad rows, active low
    output logic [3:0] col_out,     // keypad columns, one-cold
    output logic       disp_neg,
    output bcd_t       disp_bcd,
    output logic       disp_err
);

    logic     key_rdy;              // scanner to core
    logic     key_rd;               // core back to scanner
    digit_t   keypad_input;
    op_code_t operator_input;
    logic     equal_input;
    value_t   show_value;           // core to display

    input_control input_control_i (
        .clk            (clk),
        .nRST           (nRST),
        .row_in         (row_in),
        .key_rd         (key_rd),
        .col_out        (col_out),
        .key_rdy        (key_rdy),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input)
    );

    calc_core calc_core_i (
        .clk            (clk),
        .nRST           (nRST),
        .key_rdy        (key_rdy),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .key_rd         (key_rd),
        .show_value     (show_value)
    );

    display_format display_format_i (
        .clk        (clk),
        .nRST       (nRST),
        .show_value (show_value),
        .disp_neg   (disp_neg),
        .disp_bcd   (disp_bcd),
        .disp_err   (disp_err)
    );

endmodule

`default_nettype wire

// File: testbench/calculator_tb.sv
`timescale 1ns/100ps
`default_nettype none

module calculator_tb import calc_pkg::*; ();

    localparam int        CLK_HALF       = 4;            // 8 ns period
    localparam int        HOLD_CYCLES    = 30;
    localparam int        GAP_CYCLES     = 20;
    localparam int        TOTAL_KEYS     = 300;          // upper bound over all tests
    localparam int        TIMEOUT_CYCLES = TOTAL_KEYS * (HOLD_CYCLES + GAP_CYCLES) + 10000;
    localparam int        STREAM_KEYS    = 100;
    localparam key_code_t KEY_ADD  = 4'h3;               // A
    localparam key_code_t KEY_SUB  = 4'h7;               // B
    localparam key_code_t KEY_MUL  = 4'hB;               // C
    localparam key_code_t KEY_EQ   = 4'hC;               // *
    localparam key_code_t KEY_HASH = 4'hE;               // #
    localparam key_code_t KEY_NEG  = 4'hF;               // D

    logic       clk;
    logic       nRST;
    logic [3:0] row_in;
    logic [3:0] col_out;
    logic       disp_neg;
    bcd_t       disp_bcd;
    logic       disp_err;
    key_code_t  press_code;                              // key held on the pad
    logic       pressed;
    int         errors;
    int         cycles;
    value_t     m_acc;                                   // reference model state
    value_t     m_entry;
    int         m_cnt;
    op_code_t   m_pend;
    logic       m_entering;

    calculator_top calculator_top_i (
        .clk      (clk),
        .nRST     (nRST),
        .row_in   (row_in),
        .col_out  (col_out),
        .disp_neg (disp_neg),
        .disp_bcd (disp_bcd),
        .disp_err (disp_err)
    );

    // pressed row pulls low only while its column is driven low
    assign row_in = (pressed && !col_out[press_code[1:0]]) ?
                    ~(4'b0001 << press_code[3:2]) : 4'b1111;

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, key sequence never finished", cycles);
            $display("checks done, %0d errors", errors);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL time=%0t %s expected %0h actual %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // keypad legend 1 2 3 A / 4 5 6 B / 7 8 9 C / * 0 # D, -1 if not a digit
    function automatic int key_digit(input key_code_t code);
        if (code[1:0] == 2'd3)
            return -1;                                   // letter column
        if (code[3:2] == 2'd3)
            return (code[1:0] == 2'd1) ? 0 : -1;         // only 0 on bottom row
        return int'(code[3:2]) * 3 + int'(code[1:0]) + 1;
    endfunction

    function automatic key_code_t digit_key(input int d);
        if (d == 0)
            return 4'hD;
        return key_code_t'(((d - 1) / 3) * 4 + (d - 1) % 3);
    endfunction

    function automatic op_code_t key_op(input key_code_t code);
        case (code)
            KEY_ADD: return OP_ADD;
            KEY_SUB: return OP_SUB;
            KEY_MUL: return OP_MUL;
            KEY_NEG: return OP_NEG;
            default: return OP_NONE;
        endcase
    endfunction

    function automatic key_code_t op_key(input int sel);
        return (sel == 0) ? KEY_ADD : (sel == 1) ? KEY_SUB : KEY_MUL;
    endfunction

    // int math, cut back to 16 bits
    function automatic value_t wrap_arith(input op_code_t op, input value_t a, input value_t b);
        if (op == OP_ADD)
            return value_t'(int'(a) + int'(b));
        if (op == OP_SUB)
            return value_t'(int'(a) - int'(b));
        return value_t'(int'(a) * int'(b));
    endfunction

    task automatic model_key(input key_code_t code);
        int       d;
        op_code_t op;
        d  = key_digit(code);
        op = key_op(code);
        if (d >= 0) begin
            if (!m_entering) begin                       // fresh number
                m_entry    = '0;
                m_cnt      = 0;
                m_entering = 1'b1;
            end
            if (m_cnt < MAX_DIGITS) begin
                m_entry = value_t'(int'(m_entry) * 10 + d);
                m_cnt++;
            end
        end else if (op == OP_NEG) begin
            if (m_entering)
                m_entry = value_t'(-int'(m_entry));
            else
                m_acc = value_t'(-int'(m_acc));
        end else if (op != OP_NONE || code == KEY_EQ) begin
            if (m_entering)
                m_acc = (m_pend == OP_NONE) ? m_entry : wrap_arith(m_pend, m_acc, m_entry);
            if (code == KEY_EQ) begin
                if (m_entering)
                    m_pend = OP_NONE;                    // pending op used up
            end else begin
                m_pend = op;
            end
            m_entering = 1'b0;
        end
    endtask

    task automatic check_display();
        int          shown;
        int          mag;
        logic [15:0] bcd;
        shown = m_entering ? int'(m_entry) : int'(m_acc);
        mag   = (shown < 0) ? -shown : shown;
        bcd   = {4'(mag / 1000), 4'((mag / 100) % 10), 4'((mag / 10) % 10), 4'(mag % 10)};
        if (mag > DISPLAY_LIMIT)
            bcd = '0;                                    // digits blank on error
        check("disp_neg", 32'(shown < 0), 32'(disp_neg));
        check("disp_err", 32'(mag > DISPLAY_LIMIT), 32'(disp_err));
        check("disp_bcd", 32'(bcd), 32'(disp_bcd));
    endtask

    task automatic press(input key_code_t code);
        @(posedge clk);
        press_code <= code;
        pressed    <= 1'b1;
        repeat (HOLD_CYCLES) @(posedge clk);
        pressed <= 1'b0;
        repeat (GAP_CYCLES) @(posedge clk);
        model_key(code);
        @(negedge clk);                                  // outputs settled by now
        check_display();
    endtask

    task automatic type_value(input int v);
        int div;
        div = 1000;
        while (div > 1 && v / div == 0)
            div = div / 10;                              // skip leading zeros
        while (div > 0) begin
            press(digit_key((v / div) % 10));
            div = div / 10;
        end
    endtask

    initial begin
        logic [3:0]  cols_seen;
        int          n;
        clk        = 1'b0;
        nRST       = 1'b0;
        pressed    = 1'b0;
        press_code = '0;
        errors     = 0;
        m_acc      = '0;
        m_entry    = '0;
        m_cnt      = 0;
        m_pend     = OP_NONE;
        m_entering = 1'b0;
        void'($urandom(32'h04c0_ebac));
        @(negedge clk);
        check("col_out", 32'hE, 32'(col_out));           // column 0 low in reset
        repeat (3) @(posedge clk);
        nRST <= 1'b1;
        @(negedge clk);
        check_display();
        cols_seen = '0;
        repeat (8) begin                                 // free scan, no key down
            @(negedge clk);
            check("col_out one-cold", 32'd3, 32'($countones(col_out)));
            cols_seen = cols_seen | ~col_out;
        end
        check("col_out columns seen", 32'hF, 32'(cols_seen));
        for (int t = 0; t < 6; t++) begin                // entry up to five digits
            n = (t == 0) ? 5 : 1 + int'($urandom % 5);   // first group always five
            repeat (n) press(digit_key(int'($urandom % 10)));
            press(KEY_EQ);
        end
        for (int t = 0; t < 10; t++) begin               // operator chains
            type_value(int'($urandom % 100));
            repeat (2) begin
                press(op_key(int'($urandom % 3)));
                type_value(int'($urandom % 100));
            end
            if (t % 2 == 0)
                press(KEY_EQ);                           // odd chains keep going
        end
        for (int t = 0; t < 4; t++) begin                // negate in entry and after equal
            type_value(int'($urandom % 1000));
            press(KEY_NEG);
            press(KEY_EQ);
            press(KEY_NEG);
        end
        for (int t = 0; t < 3; t++) begin                // products past the limit
            type_value(100 + int'($urandom % 100));
            press(KEY_MUL);
            type_value(100 + int'($urandom % 100));
            press(KEY_EQ);
            check("disp_err after product", 32'd1, 32'(disp_err));
            check("disp_bcd after product", 32'd0, 32'(disp_bcd));
            type_value(1 + int'($urandom % 9));
            check("disp_err after small entry", 32'd0, 32'(disp_err));
            press(KEY_EQ);
        end
        press(KEY_HASH);
        for (int t = 0; t < STREAM_KEYS; t++)
            press(key_code_t'($urandom % 16));           // mixed random stream
        $display("checks done, %0d errors", errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: calculator_top.f
verilog/calc_pkg.sv
verilog/input_control.sv
verilog/calc_core.sv
verilog/display_format.sv
verilog/calculator_top.sv
testbench/calculator_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the calculator testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module calculator_tb \
    -f calculator_top.f -o calculator_sim
./obj_dir/calculator_sim | tee sim.log
if grep -q "Test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
